//--- src/fm_pkg.sv
`default_nettype none

package fm_pkg;

    localparam int NUM_SLOTS = 8;       // operator slots per scan
    localparam int SLOT_W    = 3;
    localparam int FNUM_W    = 10;
    localparam int BLOCK_W   = 3;       // octave shift
    localparam int MULT_W    = 3;       // 0 means half
    localparam int RATE_W    = 4;
    localparam int WS_W      = 2;
    localparam int FB_W      = 3;
    localparam int PHASE_W   = 18;
    localparam int ENV_W     = 9;       // attenuation, 0 loudest
    localparam int OUT_W     = 12;
    localparam int IDX_W     = 10;      // wave table index
    localparam logic [ENV_W-1:0] ENV_SILENT = 9'd511;

    typedef enum logic [1:0] {
        REG_FREQ,                       // fnum, block, mult
        REG_ENV,                        // ar, dr, sl, rr
        REG_MISC                        // kon, ws, fb
    } reg_sel_e;

    typedef struct packed {
        logic [FNUM_W-1:0]  fnum;
        logic [BLOCK_W-1:0] block;
        logic [MULT_W-1:0]  mult;
    } freq_view_t;

    typedef struct packed {
        logic [RATE_W-1:0] ar;
        logic [RATE_W-1:0] dr;
        logic [RATE_W-1:0] sl;          // sustain level, times 32
        logic [RATE_W-1:0] rr;
    } env_view_t;

    typedef struct packed {
        logic [15-1-WS_W-FB_W:0] pad;   // unused upper bits
        logic                    kon;
        logic [WS_W-1:0]         ws;
        logic [FB_W-1:0]         fb;
    } misc_view_t;

    typedef union packed {
        freq_view_t freq;
        env_view_t  env;
        misc_view_t misc;
    } reg_word_u;                       // one write word, three decodes

    typedef struct packed {
        logic [FNUM_W-1:0]  fnum;
        logic [BLOCK_W-1:0] block;
        logic [MULT_W-1:0]  mult;
        logic [RATE_W-1:0]  ar;
        logic [RATE_W-1:0]  dr;
        logic [RATE_W-1:0]  sl;
        logic [RATE_W-1:0]  rr;
        logic               kon;
        logic [WS_W-1:0]    ws;
        logic [FB_W-1:0]    fb;
    } slot_cfg_t;                       // register file entry, 38 bits

    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] slot;
        slot_cfg_t         cfg;
    } slot_beat_t;

    typedef enum logic [1:0] {
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_e;

    typedef struct packed {
        logic                    valid;
        logic [SLOT_W-1:0]       slot;
        logic signed [OUT_W-1:0] sample;
    } op_out_t;

endpackage

`default_nettype wire

//--- src/slot_regs.sv
`timescale 1ns/10ps
`default_nettype none

module slot_regs
    import fm_pkg::*;
(
    input  wire               clk,
    input  wire               arst_n,
    input  wire               reg_wr,       // one-cycle write strobe
    input  wire  [SLOT_W-1:0] reg_slot,
    input  var   reg_sel_e    reg_sel,
    input  var   reg_word_u   reg_wdata,
    input  wire               sample_en,    // starts a scan when idle
    output slot_beat_t        beat_p0
);

    slot_cfg_t         cfg_mem [NUM_SLOTS];  // per-slot settings
    logic              busy;                 // scan in progress
    logic [SLOT_W-1:0] scan_cnt;             // next slot to issue
    logic              start;
    logic [SLOT_W-1:0] issue_slot;

    always_comb begin
        start      = sample_en && !busy;     // strobes during a scan are dropped
        issue_slot = busy ? scan_cnt : '0;
    end

    // register file, only the fields of the chosen view change
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) cfg_mem[i] <= '0;
        end else if (reg_wr) begin
            case (reg_sel)
                REG_FREQ: begin
                    cfg_mem[reg_slot].fnum  <= reg_wdata.freq.fnum;
                    cfg_mem[reg_slot].block <= reg_wdata.freq.block;
                    cfg_mem[reg_slot].mult  <= reg_wdata.freq.mult;
                end
                REG_ENV: begin
                    cfg_mem[reg_slot].ar <= reg_wdata.env.ar;
                    cfg_mem[reg_slot].dr <= reg_wdata.env.dr;
                    cfg_mem[reg_slot].sl <= reg_wdata.env.sl;
                    cfg_mem[reg_slot].rr <= reg_wdata.env.rr;
                end
                REG_MISC: begin
                    cfg_mem[reg_slot].kon <= reg_wdata.misc.kon;
                    cfg_mem[reg_slot].ws  <= reg_wdata.misc.ws;
                    cfg_mem[reg_slot].fb  <= reg_wdata.misc.fb;
                end
                default: ;                   // unused select code, write dropped
            endcase
        end
    end

    // scan sequencer, one beat per cycle for slots 0 to 7
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            scan_cnt <= '0;
            beat_p0  <= '0;
        end else begin
            beat_p0.valid <= start || busy;
            beat_p0.slot  <= issue_slot;
            beat_p0.cfg   <= cfg_mem[issue_slot];   // settings sampled at issue
            if (start) begin
                busy     <= 1'b1;
                scan_cnt <= SLOT_W'(1);             // slot 0 goes out now
            end else if (busy) begin
                scan_cnt <= scan_cnt + 1'b1;
                if (scan_cnt == SLOT_W'(NUM_SLOTS - 1)) busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/key_edge.sv
`timescale 1ns/10ps
`default_nettype none

module key_edge
    import fm_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  var slot_beat_t beat_p0,
    output slot_beat_t     beat_p1,
    output logic           key_on_p1,    // rising kon seen this visit
    output logic           key_off_p1    // falling kon seen this visit
);

    logic [NUM_SLOTS-1:0] last_kon;      // kon from previous visit
    logic                 prev_kon;

    always_comb prev_kon = last_kon[beat_p0.slot];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_kon   <= '0;
            key_on_p1  <= 1'b0;
            key_off_p1 <= 1'b0;
            beat_p1    <= '0;
        end else begin
            beat_p1    <= beat_p0;       // beat chain into p1
            key_on_p1  <= beat_p0.valid && beat_p0.cfg.kon && !prev_kon;
            key_off_p1 <= beat_p0.valid && !beat_p0.cfg.kon && prev_kon;
            if (beat_p0.valid) last_kon[beat_p0.slot] <= beat_p0.cfg.kon;
        end
    end

endmodule

`default_nettype wire

//--- src/envelope_gen.sv
`timescale 1ns/10ps
`default_nettype none

module envelope_gen
    import fm_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  var slot_beat_t   beat_p1,
    input  wire              key_on_p1,
    input  wire              key_off_p1,
    output logic [ENV_W-1:0] env_p2      // attenuation for this visit
);

    env_state_e        state_mem [NUM_SLOTS];
    logic [ENV_W-1:0]  env_mem   [NUM_SLOTS];
    env_state_e        cur_state;
    env_state_e        step_state;           // state after key edges
    env_state_e        nxt_state;
    logic [ENV_W-1:0]  cur_env;
    logic [ENV_W-1:0]  nxt_env;
    logic [ENV_W-1:0]  atk_step;             // ar times 8
    logic [ENV_W-1:0]  sus_lvl;              // sl times 32
    logic [ENV_W:0]    dec_sum;              // one spare bit for overflow
    logic [ENV_W:0]    rel_sum;

    always_comb begin
        cur_state = state_mem[beat_p1.slot];
        cur_env   = env_mem[beat_p1.slot];
        atk_step  = ENV_W'({beat_p1.cfg.ar, 3'b000});
        sus_lvl   = {beat_p1.cfg.sl, 5'b00000};
        dec_sum   = {1'b0, cur_env} + (ENV_W+1)'(beat_p1.cfg.dr);
        rel_sum   = {1'b0, cur_env} + (ENV_W+1)'({beat_p1.cfg.rr, 1'b0});

        if (key_on_p1) step_state = ENV_ATTACK;
        else if (key_off_p1) step_state = ENV_RELEASE;
        else step_state = cur_state;

        nxt_state = step_state;
        nxt_env   = cur_env;
        case (step_state)
            ENV_ATTACK: begin
                if (cur_env <= atk_step) begin
                    nxt_env   = '0;              // full level reached
                    nxt_state = ENV_DECAY;
                end else begin
                    nxt_env = cur_env - atk_step;
                end
            end
            ENV_DECAY: begin
                if (dec_sum >= {1'b0, sus_lvl}) begin
                    nxt_env   = sus_lvl;         // clamp to sustain level
                    nxt_state = ENV_SUSTAIN;
                end else begin
                    nxt_env = dec_sum[ENV_W-1:0];
                end
            end
            ENV_SUSTAIN: nxt_env = cur_env;      // hold while key is down
            ENV_RELEASE: begin
                if (rel_sum > {1'b0, ENV_SILENT}) nxt_env = ENV_SILENT;
                else nxt_env = rel_sum[ENV_W-1:0];
            end
            default: nxt_state = ENV_RELEASE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                state_mem[i] <= ENV_RELEASE;
                env_mem[i]   <= ENV_SILENT;
            end
            env_p2 <= ENV_SILENT;
        end else if (beat_p1.valid) begin
            state_mem[beat_p1.slot] <= nxt_state;
            env_mem[beat_p1.slot]   <= nxt_env;
            env_p2                  <= nxt_env;  // updated value used now
        end
    end

endmodule

`default_nettype wire

//--- src/phase_gen.sv
`timescale 1ns/10ps
`default_nettype none

module phase_gen
    import fm_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  var slot_beat_t   beat_p0,
    input  var op_out_t      op_out,     // looped back for feedback
    output logic [IDX_W-1:0] index_p2
);

    logic [PHASE_W-1:0]      phase_mem [NUM_SLOTS];
    logic signed [OUT_W-1:0] fb_last   [NUM_SLOTS];  // newest output
    logic signed [OUT_W-1:0] fb_prev   [NUM_SLOTS];  // one before that
    logic [PHASE_W-1:0]      phase_cur;
    logic [PHASE_W-1:0]      base_inc;               // fnum << block
    logic [PHASE_W-1:0]      phase_inc;
    logic [SLOT_W-1:0]       slot_p1;
    logic [FB_W-1:0]         fb_p1;
    logic [IDX_W-1:0]        phase_hi_p1;            // old phase, top bits
    logic signed [OUT_W:0]   fb_sum;
    logic signed [OUT_W+7:0] fb_shl;                 // room for shift by 7
    logic signed [OUT_W+7:0] fb_term;

    always_comb begin
        phase_cur = phase_mem[beat_p0.slot];
        base_inc  = PHASE_W'(beat_p0.cfg.fnum) << beat_p0.cfg.block;
        if (beat_p0.cfg.mult == '0) phase_inc = base_inc >> 1;    // half
        else phase_inc = base_inc * PHASE_W'(beat_p0.cfg.mult);   // wraps mod 2^18
    end

    always_comb begin
        fb_sum  = fb_last[slot_p1] + fb_prev[slot_p1];
        fb_shl  = fb_sum <<< fb_p1;
        fb_term = (fb_p1 == '0) ? '0 : (fb_shl >>> 9);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                phase_mem[i] <= '0;
                fb_last[i]   <= '0;
                fb_prev[i]   <= '0;
            end
            slot_p1     <= '0;
            fb_p1       <= '0;
            phase_hi_p1 <= '0;
            index_p2    <= '0;
        end else begin
            slot_p1     <= beat_p0.slot;
            fb_p1       <= beat_p0.cfg.fb;
            phase_hi_p1 <= phase_cur[PHASE_W-1:PHASE_W-IDX_W];
            index_p2    <= phase_hi_p1 + fb_term[IDX_W-1:0];   // mod 1024
            if (beat_p0.valid) phase_mem[beat_p0.slot] <= phase_cur + phase_inc;
            if (op_out.valid) begin
                fb_prev[op_out.slot] <= fb_last[op_out.slot];  // two-deep shift
                fb_last[op_out.slot] <= op_out.sample;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/wave_shaper.sv
`timescale 1ns/10ps
`default_nettype none

module wave_shaper
    import fm_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  var slot_beat_t   beat_p2,
    input  wire [IDX_W-1:0]  index_p2,
    input  wire [ENV_W-1:0]  env_p2,
    output op_out_t          op_out
);

    localparam logic signed [OUT_W-1:0] FULL = 12'sd2047;  // peak magnitude

    logic [8:0]              abs_x;       // |h - 256|
    logic [16:0]             sq;
    logic [11:0]             sq_div;      // x squared over 32
    logic signed [OUT_W-1:0] mag;         // parabola, never negative
    logic                    neg;         // second half of the cycle
    logic signed [OUT_W-1:0] wave;
    logic signed [OUT_W-1:0] sample;

    always_comb begin
        abs_x  = index_p2[8] ? {1'b0, index_p2[7:0]} : 9'd256 - index_p2[8:0];
        sq     = abs_x * abs_x;
        sq_div = sq[16:5];
        mag    = (sq_div > 12'd2047) ? '0 : FULL - $signed(sq_div);
        neg    = index_p2[9];

        case (beat_p2.cfg.ws)
            2'd0:    wave = neg ? -mag : mag;     // plain signed
            2'd1:    wave = neg ? '0 : mag;       // half rectified
            2'd2:    wave = mag;                  // full rectified
            default: wave = neg ? -FULL : FULL;   // square
        endcase

        // env bits 8 to 5 give the coarse 6 dB steps
        if (env_p2 == ENV_SILENT) sample = '0;
        else sample = wave >>> env_p2[8:5];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_out <= '0;
        end else begin
            op_out.valid  <= beat_p2.valid;
            op_out.slot   <= beat_p2.slot;
            op_out.sample <= sample;
        end
    end

endmodule

`default_nettype wire

//--- src/fm_operator_bank.sv
`timescale 1ns/10ps
`default_nettype none

module fm_operator_bank
    import fm_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              reg_wr,
    input  wire [SLOT_W-1:0] reg_slot,
    input  var reg_sel_e     reg_sel,
    input  var reg_word_u    reg_wdata,
    input  wire              sample_en,
    output op_out_t          op_out       // one strobe per slot, p3
);

    slot_beat_t       beat_p0;
    slot_beat_t       beat_p1;
    slot_beat_t       beat_p2;            // settings for the wave stage
    logic             key_on_p1;
    logic             key_off_p1;
    logic [ENV_W-1:0] env_p2;
    logic [IDX_W-1:0] index_p2;

    slot_regs i_slot_regs (
        .clk, .arst_n, .reg_wr, .reg_slot, .reg_sel, .reg_wdata, .sample_en,
        .beat_p0
    );

    key_edge i_key_edge (
        .clk, .arst_n, .beat_p0, .beat_p1, .key_on_p1, .key_off_p1
    );

    envelope_gen i_envelope_gen (
        .clk, .arst_n, .beat_p1, .key_on_p1, .key_off_p1, .env_p2
    );

    phase_gen i_phase_gen (
        .clk, .arst_n, .beat_p0, .op_out, .index_p2
    );

    // p1 to p2 step of the beat chain
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) beat_p2 <= '0;
        else beat_p2 <= beat_p1;
    end

    wave_shaper i_wave_shaper (
        .clk, .arst_n, .beat_p2, .index_p2, .env_p2, .op_out
    );

endmodule

`default_nettype wire

//--- bench/tb_fm_operator_bank.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fm_operator_bank
    import fm_pkg::*;
();

    localparam int T3_SAMPLES  = 40;        // rectified and square waves
    localparam int T4_ATTACK   = 80;        // key held
    localparam int T4_RELEASE  = 90;        // key released
    localparam int T5_SAMPLES  = 40;        // feedback
    localparam int T6_ROUNDS   = 60;        // random register writes
    localparam int N_SAMPLES   = 2 + T3_SAMPLES + T4_ATTACK + T4_RELEASE + T5_SAMPLES + T6_ROUNDS;
    localparam int N_WRITES    = 18 + 4 + 21 + 3 * T6_ROUNDS;
    localparam int WATCHDOG_CYCLES = N_SAMPLES * 16 + N_WRITES * 2 + 16 + 500;
    localparam int S_ATK = 0;
    localparam int S_DEC = 1;
    localparam int S_SUS = 2;
    localparam int S_REL = 3;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              reg_wr;
    logic [SLOT_W-1:0] reg_slot;
    reg_sel_e          reg_sel;
    reg_word_u         reg_wdata;
    logic              sample_en;
    op_out_t           op_out;

    int          cyc = 0;                   // rising edges seen
    bit          started = 1'b0;            // first strobe sent
    string       cur_test;
    logic [31:0] rng = 32'd2;               // xorshift state seeded with 2
    int          exp_cyc  [$];              // expected strobe cycle
    int          exp_slot [$];
    int          exp_smp  [$];

    // reference model state per slot
    slot_cfg_t   cfg_m [NUM_SLOTS];
    bit          kon_m [NUM_SLOTS];
    int          st_m  [NUM_SLOTS];
    int          env_m [NUM_SLOTS];
    int          ph_m  [NUM_SLOTS];
    int          fb1_m [NUM_SLOTS];         // newest output
    int          fb2_m [NUM_SLOTS];

    fm_operator_bank i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .reg_wr    (reg_wr),
        .reg_slot  (reg_slot),
        .reg_sel   (reg_sel),
        .reg_wdata (reg_wdata),
        .sample_en (sample_en),
        .op_out    (op_out)
    );

    always #50 clk = ~clk;                  // 100 ns period

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_value(input string what, input int exp_v, input int act_v);
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
        $display("*** FAILED ***");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_event(input string msg);
        $display("%s: %s", cur_test, msg);
        $display("*** FAILED ***");
        $fatal(1, "unexpected event");
    endtask

    // one register write mirrored into the model
    task automatic write_reg(input int s, input reg_sel_e sel, input reg_word_u w);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_slot  = SLOT_W'(s);
        reg_sel   = sel;
        reg_wdata = w;
        case (sel)
            REG_FREQ: begin
                cfg_m[s].fnum  = w.freq.fnum;
                cfg_m[s].block = w.freq.block;
                cfg_m[s].mult  = w.freq.mult;
            end
            REG_ENV: begin
                cfg_m[s].ar = w.env.ar;
                cfg_m[s].dr = w.env.dr;
                cfg_m[s].sl = w.env.sl;
                cfg_m[s].rr = w.env.rr;
            end
            REG_MISC: begin
                cfg_m[s].kon = w.misc.kon;
                cfg_m[s].ws  = w.misc.ws;
                cfg_m[s].fb  = w.misc.fb;
            end
            default: ;                      // select code 3 writes nothing
        endcase
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic setup_slot(input int s, input int fnum, input int block, input int mult,
                              input int ar, input int dr, input int sl, input int rr,
                              input int kon, input int ws, input int fb);
        reg_word_u w;
        w            = '0;
        w.freq.fnum  = FNUM_W'(fnum);
        w.freq.block = BLOCK_W'(block);
        w.freq.mult  = MULT_W'(mult);
        write_reg(s, REG_FREQ, w);
        w        = '0;
        w.env.ar = RATE_W'(ar);
        w.env.dr = RATE_W'(dr);
        w.env.sl = RATE_W'(sl);
        w.env.rr = RATE_W'(rr);
        write_reg(s, REG_ENV, w);
        w          = '0;
        w.misc.kon = kon[0];
        w.misc.ws  = WS_W'(ws);
        w.misc.fb  = FB_W'(fb);
        write_reg(s, REG_MISC, w);
    endtask

    // model of one visit to slot s
    task automatic model_visit(input int s, output int smp);
        slot_cfg_t c;
        int        inc;
        int        old_ph;
        int        fbt;
        int        idx;
        int        x;
        int        mag;
        int        wave;
        c = cfg_m[s];
        if (c.kon && !kon_m[s]) st_m[s] = S_ATK;
        else if (!c.kon && kon_m[s]) st_m[s] = S_REL;
        kon_m[s] = c.kon;
        case (st_m[s])
            S_ATK: begin
                if (env_m[s] <= int'(c.ar) * 8) begin
                    env_m[s] = 0;
                    st_m[s]  = S_DEC;
                end else begin
                    env_m[s] = env_m[s] - int'(c.ar) * 8;
                end
            end
            S_DEC: begin
                if (env_m[s] + int'(c.dr) >= int'(c.sl) * 32) begin
                    env_m[s] = int'(c.sl) * 32;
                    st_m[s]  = S_SUS;
                end else begin
                    env_m[s] = env_m[s] + int'(c.dr);
                end
            end
            S_SUS: ;                        // level holds
            default: begin
                env_m[s] = env_m[s] + int'(c.rr) * 2;
                if (env_m[s] > 511) env_m[s] = 511;
            end
        endcase
        inc = int'(c.fnum) << c.block;
        if (c.mult == 0) inc = inc >> 1;    // half
        else inc = (inc * int'(c.mult)) % (1 << 18);
        old_ph   = ph_m[s];
        ph_m[s]  = (ph_m[s] + inc) % (1 << 18);
        fbt = (c.fb == 0) ? 0 : ((fb1_m[s] + fb2_m[s]) * (1 << c.fb)) >>> 9;
        idx = ((old_ph >> 8) + fbt) & 1023;
        x   = (idx & 511) - 256;
        mag = 2047 - (x * x) / 32;
        if (mag < 0) mag = 0;
        case (c.ws)
            2'd0:    wave = (idx >= 512) ? -mag : mag;
            2'd1:    wave = (idx >= 512) ? 0 : mag;
            2'd2:    wave = mag;
            default: wave = (idx >= 512) ? -2047 : 2047;
        endcase
        smp      = (env_m[s] == 511) ? 0 : (wave >>> (env_m[s] >> 5));
        fb2_m[s] = fb1_m[s];
        fb1_m[s] = smp;
    endtask

    // one sample strobe with an optional poke 3 cycles into the scan
    task automatic run_sample(input bit poke);
        int smp;
        @(negedge clk);
        sample_en = 1'b1;
        started   = 1'b1;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            model_visit(k, smp);
            exp_cyc.push_back(cyc + k + 4);     // slot k lands k+4 cycles later
            exp_slot.push_back(k);
            exp_smp.push_back(smp);
        end
        for (int i = 1; i < 16; i++) begin
            @(negedge clk);
            sample_en = poke && (i == 3);       // must be ignored by the DUT
        end
    endtask

    // output checker on the falling edge where op_out is stable
    always @(negedge clk) begin
        int act;
        act = int'($signed(op_out.sample));
        if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
            assert (op_out.valid) else report_value("op_out.valid", 1, 0);
            assert (int'(op_out.slot) == exp_slot[0])
                else report_value("op_out.slot", exp_slot[0], int'(op_out.slot));
            assert (act == exp_smp[0])
                else report_value($sformatf("sample slot %0d", exp_slot[0]), exp_smp[0], act);
            void'(exp_cyc.pop_front());
            void'(exp_slot.pop_front());
            void'(exp_smp.pop_front());
        end else begin
            assert (!op_out.valid) else report_event("op_out.valid high with no strobe due");
            if (!started) begin
                assert (act == 0) else report_value("idle sample", 0, act);
            end
        end
    end

    initial begin
        reg_wr    = 1'b0;
        reg_slot  = '0;
        reg_sel   = REG_FREQ;
        reg_wdata = '0;
        sample_en = 1'b0;
        arst_n    = 1'b0;
        cur_test  = "reset_idle";
        for (int s = 0; s < NUM_SLOTS; s++) begin
            cfg_m[s] = '0;
            kon_m[s] = 1'b0;
            st_m[s]  = S_REL;               // silent after reset
            env_m[s] = 511;
            ph_m[s]  = 0;
            fb1_m[s] = 0;
            fb2_m[s] = 0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (8) @(negedge clk);          // idle after reset

        cur_test = "scan_timing";
        run_sample(1'b1);
        run_sample(1'b1);

        cur_test = "rectified_square";
        setup_slot(0, 300, 2, 1, 15, 3, 0, 4, 1, 1, 0);
        setup_slot(1, 517, 0, 0, 15, 3, 0, 4, 1, 2, 0);
        setup_slot(2, 123, 5, 3, 15, 3, 0, 4, 1, 3, 0);
        setup_slot(3, 1023, 7, 7, 15, 3, 0, 4, 1, 1, 0);    // increment wraps
        setup_slot(4, 64, 3, 0, 15, 3, 0, 4, 1, 3, 0);
        setup_slot(5, 900, 4, 5, 15, 3, 0, 4, 1, 2, 0);
        repeat (T3_SAMPLES) run_sample(1'b0);

        cur_test = "envelope";
        setup_slot(6, 200, 3, 2, 2, 5, 6, 3, 1, 3, 0);      // slow attack then decay to 192
        repeat (T4_ATTACK) run_sample(1'b0);
        reg_wdata         = '0;
        reg_wdata.misc.ws = 2'd3;
        write_reg(6, REG_MISC, reg_wdata);                  // key off
        repeat (T4_RELEASE) run_sample(1'b0);

        cur_test = "feedback";
        for (int s = 0; s < 7; s++) begin
            setup_slot(s, 100 + 97 * s, s, s, 15, 0, 0, 2, 1, 0, s + 1);
        end
        repeat (T5_SAMPLES) run_sample(1'b0);

        cur_test = "register_views";
        for (int r = 0; r < T6_ROUNDS; r++) begin
            repeat (3) begin
                logic [31:0] a;
                logic [31:0] b;
                a = next_rand();
                b = next_rand();
                write_reg(int'(a % NUM_SLOTS), reg_sel_e'(a[15:0] % 3), reg_word_u'(b[15:0]));
            end
            run_sample(1'b0);
        end

        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- flist.f
src/fm_pkg.sv
src/slot_regs.sv
src/key_edge.sv
src/envelope_gen.sv
src/phase_gen.sv
src/wave_shaper.sv
src/fm_operator_bank.sv
bench/tb_fm_operator_bank.sv

//--- Bender.yml
package:
  name: fm_operator_bank

sources:
  - src/fm_pkg.sv
  - src/slot_regs.sv
  - src/key_edge.sv
  - src/envelope_gen.sv
  - src/phase_gen.sv
  - src/wave_shaper.sv
  - src/fm_operator_bank.sv
  - target: test
    files:
      - bench/tb_fm_operator_bank.sv
